/* Makefile */
# Verilator build and run of the sram test chip testbench

VERILATOR ?= verilator
TOP       ?= tb_sram_testchip
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "No errors" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/dout_capture.sv */
// ==================================================
// read data capture
// keeps the accessed bank's two words for the chain
// ==================================================

`timescale 1ns/1ps
`include "sram_test_settings.svh"

module dout_capture import sram_test_pkg::*; (
   input  logic         clk,
   input  logic         rstn,
   input  logic         capture_en_i,
   input  bank_vec_t    csb0_i,
   input  data_t        bank_dout0_i [`NUM_BANKS],
   input  data_t        bank_dout1_i [`NUM_BANKS],
   output sram_result_t result_o
);

   // selects of the access edge, one cycle late
   bank_vec_t    csb_q;
   logic         hit;
   sram_result_t pick;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         csb_q <= '1;
      end else begin
         csb_q <= csb0_i;
      end
   end

   // steer by whichever bank answered
   always_comb begin
      hit  = 1'b0;
      pick = '0;
      for (int b = 0; b < `NUM_BANKS; b++) begin
         if (!csb_q[b]) begin
            hit        = 1'b1;
            pick.dout0 = bank_dout0_i[b];
            pick.dout1 = bank_dout1_i[b];
         end
      end
   end

   // nothing selected, old result stays
   always_ff @(posedge clk) begin
      if (!rstn) begin
         result_o <= '0;
      end else if (capture_en_i && hit) begin
         result_o <= pick;
      end
   end

endmodule

/* rtl/scan_chain.sv */
// ==================================================
// scan chain
// serial command in, parallel result load, serial out
// ==================================================

`timescale 1ns/1ps
`include "sram_test_settings.svh"

module scan_chain import sram_test_pkg::*; (
   input  logic         clk,
   input  logic         rstn,
   input  logic         shift_i,
   input  logic         scan_i,
   input  logic         result_load_i,
   input  sram_result_t result_i,
   output logic         scan_o,
   output sram_cmd_t    cmd_o
);

   // {result, command}, msb leaves first
   logic [`CHAIN_W-1:0] chain_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         chain_q <= '0;
      end else if (result_load_i) begin
         // command bits kept, only result overwritten
         chain_q[`CMD_W +: `RESULT_W] <= result_i;
      end else if (shift_i) begin
         // new bit enters at lsb
         chain_q <= {chain_q[`CHAIN_W-2:0], scan_i};
      end
   end

   assign scan_o = chain_q[`CHAIN_W-1];

   // command field is the low part of the chain
   assign cmd_o = sram_cmd_t'(chain_q[`CMD_W-1:0]);

endmodule

/* rtl/sram_bank.sv */
// ==================================================
// behavioral 1rw1r memory bank
// byte-masked writes, registered read data on both ports
// ==================================================

`timescale 1ns/1ps
`include "sram_test_settings.svh"

module sram_bank import sram_test_pkg::*; #(
   parameter int WIDTH = 32
) (
   input  logic             clk,
   // port 0, read/write
   input  logic             csb0_i,
   input  logic             web_i,
   input  wmask_t           wmask_i,
   input  addr_t            addr0_i,
   input  logic [WIDTH-1:0] din_i,
   // port 1, read only
   input  logic             csb1_i,
   input  addr_t            addr1_i,
   output logic [WIDTH-1:0] dout0_o,
   output logic [WIDTH-1:0] dout1_o
);

   // one mask bit per byte lane present in this bank
   localparam int LANES = WIDTH / 8;

   logic [WIDTH-1:0] mem [`SRAM_DEPTH];

   // port 0
   // nonblocking read returns the word from before the write
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web_i) begin
            for (int b = 0; b < LANES; b++) begin
               if (wmask_i[b]) begin
                  mem[addr0_i][b*8 +: 8] <= din_i[b*8 +: 8];
               end
            end
         end
         dout0_o <= mem[addr0_i];
      end
   end

   // port 1
   // same-address read during a port 0 write sees old data
   always_ff @(posedge clk) begin
      if (!csb1_i) begin
         dout1_o <= mem[addr1_i];
      end
   end

endmodule

/* rtl/sram_test_pkg.sv */
// ==================================================
// sram test chip types
// command, bank bus and result structs, ctrl states
// ==================================================

package sram_test_pkg;

   `include "sram_test_settings.svh"

   // plain vectors
   typedef logic [`ADDR_W-1:0]              addr_t;
   typedef logic [`DATA_W-1:0]              data_t;
   typedef logic [`WMASK_W-1:0]             wmask_t;
   typedef logic [$clog2(`NUM_BANKS)-1:0]   bank_sel_t;
   // one bit per bank, active low when used as chip select
   typedef logic [`NUM_BANKS-1:0]           bank_vec_t;

   // command field of the chain, msb first
   typedef struct packed {
      bank_sel_t bank;
      logic      we;
      wmask_t    wmask;
      addr_t     addr0;
      addr_t     addr1;
      data_t     din;
   } sram_cmd_t;

   // result field of the chain
   typedef struct packed {
      data_t dout0;
      data_t dout1;
   } sram_result_t;

   // shared bus driven to every bank
   typedef struct packed {
      bank_vec_t csb0;
      bank_vec_t csb1;
      logic      web;
      wmask_t    wmask;
      addr_t     addr0;
      addr_t     addr1;
      data_t     din;
   } sram_port_t;

   typedef enum logic [1:0] {IDLE, ACCESS, CAPTURE, UPDATE} ctrl_state_t;

endpackage

/* rtl/sram_testchip_top.sv */
// ==================================================
// sram test chip top
// scan chain, controller, four banks, read capture
// ==================================================

`timescale 1ns/1ps
`include "sram_test_settings.svh"

module sram_testchip_top import sram_test_pkg::*; (
   input  logic clk,
   input  logic rstn,
   input  logic scan_en_i,
   input  logic scan_i,
   input  logic load_i,
   input  logic global_csb_i,
   output logic scan_o,
   output logic ready_o
);

   sram_cmd_t    cmd;
   sram_result_t result;
   sram_port_t   port;
   logic         capture_en;
   logic         result_load;

   // per bank read words, all widened to data_t
   data_t bank_dout0 [`NUM_BANKS];
   data_t bank_dout1 [`NUM_BANKS];

   // bank 0 raw outputs
   logic [`NARROW_W-1:0] narrow_dout0;
   logic [`NARROW_W-1:0] narrow_dout1;

   // shifting only while idle, busy shifts dropped
   scan_chain u_chain (
      .clk           (clk),
      .rstn          (rstn),
      .shift_i       (scan_en_i & ready_o),
      .scan_i        (scan_i),
      .result_load_i (result_load),
      .result_i      (result),
      .scan_o        (scan_o),
      .cmd_o         (cmd)
   );

   test_ctrl u_ctrl (
      .clk           (clk),
      .rstn          (rstn),
      .load_i        (load_i),
      .scan_en_i     (scan_en_i),
      .global_csb_i  (global_csb_i),
      .cmd_i         (cmd),
      .port_o        (port),
      .capture_en_o  (capture_en),
      .result_load_o (result_load),
      .ready_o       (ready_o)
   );

   // bank 0, 8 bits wide
   sram_bank #(.WIDTH(`NARROW_W)) u_bank0 (
      .clk     (clk),
      .csb0_i  (port.csb0[0]),
      .web_i   (port.web),
      .wmask_i (port.wmask),
      .addr0_i (port.addr0),
      .din_i   (port.din[`NARROW_W-1:0]),
      .csb1_i  (port.csb1[0]),
      .addr1_i (port.addr1),
      .dout0_o (narrow_dout0),
      .dout1_o (narrow_dout1)
   );
   // upper bits read as zero
   assign bank_dout0[0] = {{(`DATA_W-`NARROW_W){1'b0}}, narrow_dout0};
   assign bank_dout1[0] = {{(`DATA_W-`NARROW_W){1'b0}}, narrow_dout1};

   // banks 1 to 3, full width
   for (genvar i = 1; i < `NUM_BANKS; i++) begin : g_wide
      sram_bank #(.WIDTH(`DATA_W)) u_bank (
         .clk     (clk),
         .csb0_i  (port.csb0[i]),
         .web_i   (port.web),
         .wmask_i (port.wmask),
         .addr0_i (port.addr0),
         .din_i   (port.din),
         .csb1_i  (port.csb1[i]),
         .addr1_i (port.addr1),
         .dout0_o (bank_dout0[i]),
         .dout1_o (bank_dout1[i])
      );
   end

   dout_capture u_capture (
      .clk          (clk),
      .rstn         (rstn),
      .capture_en_i (capture_en),
      .csb0_i       (port.csb0),
      .bank_dout0_i (bank_dout0),
      .bank_dout1_i (bank_dout1),
      .result_o     (result)
   );

endmodule

/* rtl/test_ctrl.sv */
// ==================================================
// test controller
// turns one loaded command into one bank access
// ==================================================

`timescale 1ns/1ps

module test_ctrl import sram_test_pkg::*; (
   input  logic       clk,
   input  logic       rstn,
   input  logic       load_i,
   input  logic       scan_en_i,
   input  logic       global_csb_i,
   input  sram_cmd_t  cmd_i,
   output sram_port_t port_o,
   output logic       capture_en_o,
   output logic       result_load_o,
   output logic       ready_o
);

   ctrl_state_t state_q;
   logic        start;
   bank_vec_t   sel_n;

   // control part of the bus
   bank_vec_t csb0_q;
   bank_vec_t csb1_q;
   logic      web_q;

   // payload part of the bus
   wmask_t wmask_q;
   addr_t  addr0_q;
   addr_t  addr1_q;
   data_t  din_q;

   // load accepted only while idle and not shifting
   assign start = load_i && !scan_en_i && (state_q == IDLE);

   // one-cold bank decode, override deselects everything
   always_comb begin
      sel_n = '1;
      if (!global_csb_i) begin
         sel_n[cmd_i.bank] = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q <= IDLE;
         csb0_q  <= '1;
         csb1_q  <= '1;
         web_q   <= 1'b1;
      end else begin
         case (state_q)
            IDLE: begin
               if (start) begin
                  state_q <= ACCESS;
                  csb0_q  <= sel_n;
                  csb1_q  <= sel_n;
                  web_q   <= ~cmd_i.we;
               end
            end
            // banks see the bus on this edge, then release
            ACCESS: begin
               state_q <= CAPTURE;
               csb0_q  <= '1;
               csb1_q  <= '1;
               web_q   <= 1'b1;
            end
            CAPTURE: state_q <= UPDATE;
            default: state_q <= IDLE;
         endcase
      end
   end

   // address and data follow the accepted command
   always_ff @(posedge clk) begin
      if (start) begin
         wmask_q <= cmd_i.wmask;
         addr0_q <= cmd_i.addr0;
         addr1_q <= cmd_i.addr1;
         din_q   <= cmd_i.din;
      end
   end

   assign port_o = '{csb0: csb0_q, csb1: csb1_q, web: web_q, wmask: wmask_q,
                     addr0: addr0_q, addr1: addr1_q, din: din_q};

   // bank outputs valid one cycle after access
   assign capture_en_o  = (state_q == CAPTURE);
   assign result_load_o = (state_q == UPDATE);
   assign ready_o       = (state_q == IDLE);

endmodule

/* sources.f */
+incdir+.
rtl/sram_test_pkg.sv
rtl/scan_chain.sv
rtl/test_ctrl.sv
rtl/sram_bank.sv
rtl/dout_capture.sv
rtl/sram_testchip_top.sv
verification/tb_sram_testchip.sv

/* sram_test_settings.svh */
// ==================================================
// sram test chip settings
// bank count, bus widths, depth and scan chain length
// ==================================================

`ifndef SRAM_TEST_SETTINGS_SVH
`define SRAM_TEST_SETTINGS_SVH

// bank array
`define NUM_BANKS 4
`define ADDR_W 8
`define SRAM_DEPTH (1 << `ADDR_W)

// data path, bank 0 is the narrow one
`define DATA_W 32
`define NARROW_W 8
`define WMASK_W 4

// scan chain fields: {result, command}
`define CMD_W 55
`define RESULT_W 64
`define CHAIN_W (`RESULT_W + `CMD_W)

`endif

/* verification/tb_sram_testchip.sv */
// ==================================================
// sram test chip testbench
// lfsr commands over the scan pins, checked against a bank model
// ==================================================

`timescale 1ns/1ps
`include "sram_test_settings.svh"

module tb_sram_testchip import sram_test_pkg::*; ();

   localparam int TIMEOUT = 50;

   logic clk;
   logic rstn;
   logic scan_en;
   logic scan_in;
   logic load;
   logic global_csb;
   logic scan_out;
   logic ready;

   // random source
   logic [31:0] lfsr;

   // bank model with a flag per fully written entry
   data_t model_mem [`NUM_BANKS][`SRAM_DEPTH];
   logic  model_ok  [`NUM_BANKS][`SRAM_DEPTH];

   // expected result of the last access kept for override loads
   sram_result_t last_exp;
   logic         last_v0;
   logic         last_v1;

   int   checks;
   int   errors;
   int   t_checks;
   int   t_errors;
   logic hung;

   sram_testchip_top UUT (
      .clk          (clk),
      .rstn         (rstn),
      .scan_en_i    (scan_en),
      .scan_i       (scan_in),
      .load_i       (load),
      .global_csb_i (global_csb),
      .scan_o       (scan_out),
      .ready_o      (ready)
   );

   always #4 clk = ~clk;

   // fibonacci taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one step per bit
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic sram_cmd_t make_cmd(bank_sel_t b, logic we, wmask_t m,
                                          addr_t a0, addr_t a1, data_t d);
      return '{bank: b, we: we, wmask: m, addr0: a0, addr1: a1, din: d};
   endfunction

   task automatic compare_word(string name, string what, logic [63:0] exp,
                               logic [63:0] act);
      checks++;
      t_checks++;
      if (act !== exp) begin
         $display("Error %s %s: expected %h, actual %h", name, what, exp, act);
         errors++;
         t_errors++;
      end
   endtask

   task automatic note_failure(string msg);
      $display("%s", msg);
      errors++;
      t_errors++;
   endtask

   task automatic end_test(string name);
      $display("test %-12s %0d checks, %0d errors", name, t_checks, t_errors);
      t_checks = 0;
      t_errors = 0;
   endtask

   // bank 0 has lane 0 only and reads upper bits as zero
   task automatic model_write(int b, addr_t a, wmask_t m, data_t d);
      if (b == 0) begin
         if (m[0]) begin
            model_mem[0][a] = {24'h0, d[7:0]};
            model_ok[0][a]  = 1'b1;
         end
      end else begin
         for (int k = 0; k < 4; k++) begin
            if (m[k]) begin
               model_mem[b][a][k*8 +: 8] = d[k*8 +: 8];
            end
         end
         if (m == 4'hf) begin
            model_ok[b][a] = 1'b1;
         end
      end
   endtask

   // msb first in and old chain collected msb first
   task automatic shift_word(input logic [`CHAIN_W-1:0] word_in,
                             output logic [`CHAIN_W-1:0] word_out);
      for (int i = `CHAIN_W-1; i >= 0; i--) begin
         word_out[i] = scan_out;
         scan_in = word_in[i];
         scan_en = 1'b1;
         @(posedge clk);
         #1;
      end
      scan_en = 1'b0;
      scan_in = 1'b0;
   endtask

   // one command shifted in, loaded, waited on and shifted back out
   task automatic run_access(string name, sram_cmd_t cmd, logic gcsb, logic poke);
      logic [`CHAIN_W-1:0] dummy;
      logic [`CHAIN_W-1:0] got;
      sram_result_t        exp;
      sram_result_t        got_res;
      logic                v0;
      logic                v1;
      int                  cycles;
      int                  b;
      if (!hung) begin
         b   = int'(cmd.bank);
         exp = last_exp;
         v0  = last_v0;
         v1  = last_v1;
         // override keeps the previous result
         if (!gcsb) begin
            exp.dout0 = model_mem[b][cmd.addr0];
            exp.dout1 = model_mem[b][cmd.addr1];
            v0 = model_ok[b][cmd.addr0];
            v1 = model_ok[b][cmd.addr1];
            if (cmd.we) begin
               model_write(b, cmd.addr0, cmd.wmask, cmd.din);
            end
         end
         shift_word({{`RESULT_W{1'b0}}, cmd}, dummy);
         load = 1'b1;
         global_csb = gcsb;
         @(posedge clk);
         #1;
         cycles = 0;
         if (poke) begin
            if (ready) begin
               note_failure({"ready_o did not drop after the load in test ", name});
            end
            // load held high with scan_en low while busy
            @(posedge clk);
            #1;
            cycles++;
            load = 1'b0;
            // then a shift attempt while busy
            scan_en = 1'b1;
            scan_in = 1'b1;
            @(posedge clk);
            #1;
            cycles++;
            scan_en = 1'b0;
            scan_in = 1'b0;
         end
         load = 1'b0;
         global_csb = 1'b0;
         while (!ready && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
         end
         if (!ready) begin
            note_failure({"timeout, ready_o stayed low in test ", name});
            hung = 1'b1;
         end else begin
            compare_word(name, "latency", 64'(3), 64'(cycles));
            shift_word('0, got);
            got_res = sram_result_t'(got[`CHAIN_W-1:`CMD_W]);
            if (v0) begin
               compare_word(name, "dout0", 64'(exp.dout0), 64'(got_res.dout0));
            end
            if (v1) begin
               compare_word(name, "dout1", 64'(exp.dout1), 64'(got_res.dout1));
            end
            // command bits survive the result load
            compare_word(name, "command", 64'(cmd), 64'(got[`CMD_W-1:0]));
            last_exp = exp;
            last_v0  = v0;
            last_v1  = v1;
         end
      end
   endtask

   task automatic test_reset();
      logic [`CHAIN_W-1:0] got;
      if (!ready) begin
         note_failure("ready_o low after reset");
      end
      shift_word('0, got);
      checks++;
      t_checks++;
      if (got !== '0) begin
         $display("Error reset chain: expected 0, actual %h", got);
         errors++;
         t_errors++;
      end
      end_test("reset");
   endtask

   task automatic test_full_write();
      bank_sel_t b;
      addr_t     a;
      for (int i = 0; i < 16; i++) begin
         b = bank_sel_t'(rand_bits(2));
         a = addr_t'(rand_bits(8));
         run_access("full_write", make_cmd(b, 1'b1, 4'hf, a, a, rand_bits(32)), 1'b0, 1'b0);
         run_access("full_write", make_cmd(b, 1'b0, 4'hf, a, a, '0), 1'b0, 1'b0);
      end
      end_test("full_write");
   endtask

   // every bank in turn so bank 0 sees random masks too
   task automatic test_partial_mask();
      bank_sel_t b;
      addr_t     a;
      wmask_t    m;
      for (int i = 0; i < 12; i++) begin
         b = bank_sel_t'(i % 4);
         a = addr_t'(rand_bits(8));
         m = wmask_t'(rand_bits(4));
         // lane 0 alternates so bank 0 sees masked and unmasked writes
         m[0] = i[2];
         run_access("partial", make_cmd(b, 1'b1, 4'hf, a, a, rand_bits(32)), 1'b0, 1'b0);
         run_access("partial", make_cmd(b, 1'b1, m, a, a, rand_bits(32)), 1'b0, 1'b0);
         run_access("partial", make_cmd(b, 1'b0, 4'h0, a, a, '0), 1'b0, 1'b0);
      end
      end_test("partial");
   endtask

   task automatic test_port1();
      bank_sel_t b;
      addr_t     a;
      addr_t     a2;
      for (int i = 0; i < 4; i++) begin
         b  = bank_sel_t'(rand_bits(2));
         a  = addr_t'(rand_bits(8));
         a2 = a ^ 8'h5a;
         run_access("port1", make_cmd(b, 1'b1, 4'hf, a, a, rand_bits(32)), 1'b0, 1'b0);
         run_access("port1", make_cmd(b, 1'b1, 4'hf, a2, a2, rand_bits(32)), 1'b0, 1'b0);
         run_access("port1", make_cmd(b, 1'b0, 4'h0, a, a2, '0), 1'b0, 1'b0);
         // old word expected on both ports for a same-address write
         run_access("port1", make_cmd(b, 1'b1, 4'hf, a, a, rand_bits(32)), 1'b0, 1'b0);
         run_access("port1", make_cmd(b, 1'b0, 4'h0, a, a, '0), 1'b0, 1'b0);
      end
      end_test("port1");
   endtask

   task automatic test_global_csb();
      bank_sel_t b;
      addr_t     a;
      for (int i = 0; i < 4; i++) begin
         b = bank_sel_t'(rand_bits(2));
         a = addr_t'(rand_bits(8));
         run_access("global_csb", make_cmd(b, 1'b1, 4'hf, a, a, rand_bits(32)), 1'b0, 1'b0);
         run_access("global_csb", make_cmd(b, 1'b0, 4'h0, a, a, '0), 1'b0, 1'b0);
         run_access("global_csb", make_cmd(b, 1'b1, 4'hf, a, a, rand_bits(32)), 1'b1, 1'b0);
         run_access("global_csb", make_cmd(b, 1'b0, 4'h0, a, a, '0), 1'b0, 1'b0);
      end
      end_test("global_csb");
   endtask

   // a second load would show up as the new word on dout0
   task automatic test_busy_load();
      bank_sel_t b;
      addr_t     a;
      for (int i = 0; i < 4; i++) begin
         b = bank_sel_t'(rand_bits(2));
         a = addr_t'(rand_bits(8));
         run_access("busy_load", make_cmd(b, 1'b1, 4'hf, a, a, rand_bits(32)), 1'b0, 1'b0);
         run_access("busy_load", make_cmd(b, 1'b1, 4'hf, a, a, rand_bits(32)), 1'b0, 1'b1);
         run_access("busy_load", make_cmd(b, 1'b0, 4'h0, a, a, '0), 1'b0, 1'b0);
      end
      end_test("busy_load");
   endtask

   initial begin
      lfsr       = 32'h445c_ff3a;
      clk        = 1'b0;
      rstn       = 1'b0;
      scan_en    = 1'b0;
      scan_in    = 1'b0;
      load       = 1'b0;
      global_csb = 1'b0;
      checks     = 0;
      errors     = 0;
      t_checks   = 0;
      t_errors   = 0;
      hung       = 1'b0;
      last_exp   = '0;
      last_v0    = 1'b0;
      last_v1    = 1'b0;
      for (int b = 0; b < `NUM_BANKS; b++) begin
         for (int a = 0; a < `SRAM_DEPTH; a++) begin
            model_ok[b][a] = 1'b0;
         end
      end
      repeat (8) @(posedge clk);
      #1;
      rstn = 1'b1;
      test_reset();
      test_full_write();
      test_partial_mask();
      test_port1();
      test_global_csb();
      test_busy_load();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule
